// File: files.f
+incdir+.
rv_pkg.sv
rv_issue.sv
rv_decode.sv
rv_regfile.sv
rv_alu.sv
rv_retire.sv
rv_core.sv
rv_core_asserts.sv
rv_core_tb.sv

// File: run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f files.f --top-module rv_core_tb \
    -o rv_core_sim && ./obj_dir/rv_core_sim > sim.log 2>&1 || echo "simulation did not complete"
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: rv_alu.sv
`timescale 1ns/10ps

module rv_alu (
    input  rv_pkg::AluOp op,
    input  rv_pkg::Word  a,
    input  rv_pkg::Word  b,
    output rv_pkg::Word  result
);

    logic [4:0]  shamt;
    logic        lessSigned;
    logic        lessUnsigned;
    rv_pkg::Word sum;
    rv_pkg::Word diff;

    assign shamt        = b[4:0]; // RV32 shifts use 5 bits
    assign sum          = a + b;
    assign diff         = a - b;
    assign lessSigned   = $signed(a) < $signed(b);
    assign lessUnsigned = a < b;

    always_comb begin
        case (op)
            rv_pkg::ADD: begin
                result = sum;
            end
            rv_pkg::SUB: begin
                result = diff;
            end
            rv_pkg::SLL: begin
                result = a << shamt;
            end
            rv_pkg::SLT: begin
                result = rv_pkg::Word'(lessSigned); // 0 or 1
            end
            rv_pkg::SLTU: begin
                result = rv_pkg::Word'(lessUnsigned);
            end
            rv_pkg::XOR: begin
                result = a ^ b;
            end
            rv_pkg::SRL: begin
                result = a >> shamt;
            end
            rv_pkg::SRA: begin
                result = rv_pkg::Word'($signed(a) >>> shamt); // Copies sign bit in
            end
            rv_pkg::OR: begin
                result = a | b;
            end
            rv_pkg::AND: begin
                result = a & b;
            end
            rv_pkg::PASSB: begin
                result = b;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

// File: rv_cfg.svh
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// RV32I data path width, also the instruction and PC width
`define RV_XLEN 32

// Integer register file depth
`define RV_NREGS 32

// Hard-wired zero register
`define RV_X0 0

// Cycle limit for any wait in the testbench
`define RV_TIMEOUT 50

`endif

// File: rv_core.sv
`timescale 1ns/10ps

module rv_core (
    input  logic               clk,
    input  logic               arstN,
    input  logic               instrValid,
    input  rv_pkg::Instruction instr,
    input  rv_pkg::Word        pc,
    output rv_pkg::WbResult    wb,
    output logic               illegal
);

    rv_pkg::IssueSlot slot;
    rv_pkg::ExecCmd   cmd;
    rv_pkg::Word      rdata1;
    rv_pkg::Word      rdata2;
    rv_pkg::Word      aluA;
    rv_pkg::Word      aluB;
    rv_pkg::Word      aluResult;
    logic             writeEn;
    rv_pkg::RegAddr   wAddr;
    rv_pkg::Word      wData;

    rv_issue issue (
        .clk, .arstN, .instrValid, .instr, .pc,
        .slot
    );

    rv_decode decode (
        .slot,
        .cmd
    );

    rv_regfile regfile (
        .clk, .arstN,
        .rs1(cmd.rs1), .rs2(cmd.rs2),
        .rdata1, .rdata2,
        .writeEn, .wAddr, .wData
    );

    // Operand select, pc for AUIPC and imm for immediate forms
    assign aluA = cmd.usePc ? slot.pc : rdata1;
    assign aluB = cmd.useImm ? cmd.imm : rdata2;

    rv_alu alu (
        .op(cmd.aluOp),
        .a(aluA),
        .b(aluB),
        .result(aluResult)
    );

    rv_retire retire (
        .clk, .arstN,
        .cmd, .aluResult,
        .wb, .illegal,
        .writeEn, .wAddr, .wData
    );

endmodule

// File: rv_core_asserts.sv
`timescale 1ns/10ps

module rv_core_asserts (
    input logic             clk,
    input logic             arstN,
    input rv_pkg::IssueSlot slot,
    input rv_pkg::WbResult  wb,
    input logic             illegal
);

    // Retire reports a writeback or an illegal word, never both
    noDoublePulse: assert property (@(posedge clk) disable iff (!arstN)
        !(wb.valid && illegal))
        else $error("writeback and illegal pulses high in the same cycle");

    quietInReset: assert property (@(posedge clk) !arstN |-> (!wb.valid && !illegal))
        else $error("result pulse seen while reset is asserted");

    oneResultPerSlot: assert property (@(posedge clk) disable iff (!arstN)
        slot.valid |=> (wb.valid != illegal))
        else $error("issued instruction did not give exactly one result pulse");

endmodule

bind rv_core rv_core_asserts asserts (
    .clk, .arstN, .slot, .wb, .illegal
);

// File: rv_core_tb.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_core_tb;

    logic               clk;
    logic               arstN;
    logic               instrValid;
    rv_pkg::Instruction instr;
    rv_pkg::Word        pc;
    rv_pkg::WbResult    wb;
    logic               illegal;

    int cycleCount = 0;
    int testCount  = 0;
    int errCount   = 0;
    bit driveDone  = 0;
    bit timedOut   = 0;

    // Outstanding instructions in issue order
    string           expName[$];
    bit              expIsWb[$];
    rv_pkg::WbResult expWb[$];
    int              expIssue[$];

    rv_core dut (
        .clk, .arstN, .instrValid, .instr, .pc,
        .wb, .illegal
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycleCount <= cycleCount + 1;

    task automatic checkWb(input string name, input rv_pkg::WbResult expected,
                           input rv_pkg::WbResult actual);
        if (actual !== expected) begin
            errCount++;
            $display("Error: %s expected valid=%0b rd=%0d data=%h, actual valid=%0b rd=%0d data=%h",
                     name, expected.valid, expected.rd, expected.data,
                     actual.valid, actual.rd, actual.data);
        end else begin
            $display("ok    %s rd=%0d data=%h", name, actual.rd, actual.data);
        end
    endtask

    task automatic checkIllegal(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errCount++;
            $display("Error: %s expected illegal=%0b, actual illegal=%0b", name, expected, actual);
        end else begin
            $display("ok    %s illegal", name);
        end
    endtask

    // Reads the pattern file and issues one instruction per line
    task automatic driveAll();
        int              fd;
        int              n;
        int              gap;
        string           line;
        string           name;
        string           kind;
        rv_pkg::Word     instrWord;
        rv_pkg::Word     pcWord;
        rv_pkg::Word     rdWord;
        rv_pkg::Word     dataWord;
        rv_pkg::WbResult exp;
        fd = $fopen("rv_patterns.txt", "r");
        if (fd == 0) begin
            $display("Could not open rv_patterns.txt");
            errCount++;
            driveDone = 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) == 0) continue;
            n = $sscanf(line, "%s %h %h %s %h %h", name, instrWord, pcWord, kind, rdWord,
                        dataWord);
            if (n <= 0) continue;
            if (name[0] == "#") continue;
            if (name == "--") begin // Group boundary gets a random idle gap
                gap = $urandom % 3;
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
                continue;
            end
            if (n != 6 || (kind != "wb" && kind != "illegal")) begin
                $display("Pattern line for %s could not be understood", name);
                errCount++;
                continue;
            end
            exp = '{valid: 1'b1, rd: rv_pkg::RegAddr'(rdWord), data: dataWord};
            instrValid = 1'b1;
            instr      = rv_pkg::Instruction'(instrWord);
            pc         = pcWord;
            expName.push_back(name);
            expIsWb.push_back(kind == "wb");
            expWb.push_back(exp);
            expIssue.push_back(cycleCount);
            @(posedge clk);
            #2;
            instrValid = 1'b0;
        end
        $fclose(fd);
        driveDone = 1;
    endtask

    // Matches each result pulse against the oldest outstanding instruction
    task automatic collectResults();
        int    idle;
        int    waited;
        string name;
        idle = 0;
        while (!driveDone || expName.size() > 0) begin
            if (expName.size() == 0) begin
                @(negedge clk);
                if (wb.valid || illegal) begin
                    errCount++;
                    $display("A result pulse arrived with no instruction outstanding");
                end
                idle++;
                if (idle > `RV_TIMEOUT) begin
                    $display("Stimulus stopped arriving before the pattern file ended");
                    timedOut = 1;
                    break;
                end
            end else begin
                idle   = 0;
                waited = 0;
                @(negedge clk);
                while (!(wb.valid || illegal) && waited < `RV_TIMEOUT) begin
                    @(negedge clk);
                    waited++;
                end
                name = expName.pop_front();
                if (!(wb.valid || illegal)) begin
                    $display("No writeback or illegal pulse came for %s", name);
                    timedOut = 1;
                    break;
                end
                testCount++;
                if (wb.valid && illegal) begin
                    errCount++;
                    $display("%s raised the writeback and illegal pulses together", name);
                end
                if (cycleCount - expIssue[0] != 2) begin
                    errCount++;
                    $display("%s retired %0d cycles after issue instead of 2", name,
                             cycleCount - expIssue[0]);
                end
                if (expIsWb[0]) begin
                    checkWb(name, expWb[0], wb);
                end else begin
                    checkIllegal(name, 1'b1, illegal);
                end
                void'(expIsWb.pop_front());
                void'(expWb.pop_front());
                void'(expIssue.pop_front());
            end
        end
    endtask

    initial begin
        void'($urandom(32'hc042));
        arstN      = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        repeat (2) @(posedge clk);
        #2;
        if (wb.valid || illegal) begin
            errCount++;
            $display("A result pulse was high while reset was asserted");
        end
        arstN = 1'b1;
        fork
            driveAll();
            collectResults();
        join
        $display("Tests checked: %0d, failures: %0d", testCount, errCount);
        if (errCount == 0 && !timedOut && testCount > 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
    input  rv_pkg::IssueSlot slot,
    output rv_pkg::ExecCmd   cmd
);

    rv_pkg::RiInstr ri;
    rv_pkg::RrInstr rr;
    rv_pkg::UInstr  u;

    // funct3 to ALU operation, alt is funct7 bit 5
    function automatic rv_pkg::AluOp mapFunct3(
        input rv_pkg::Funct3 f3,
        input logic alt,
        input logic isReg
    );
        rv_pkg::AluOp op;
        case (f3)
            rv_pkg::F3_ADD:  op = (isReg && alt) ? rv_pkg::SUB : rv_pkg::ADD; // No SUBI
            rv_pkg::F3_SLL:  op = rv_pkg::SLL;
            rv_pkg::F3_SLT:  op = rv_pkg::SLT;
            rv_pkg::F3_SLTU: op = rv_pkg::SLTU;
            rv_pkg::F3_XOR:  op = rv_pkg::XOR;
            rv_pkg::F3_SRLA: op = alt ? rv_pkg::SRA : rv_pkg::SRL;
            rv_pkg::F3_OR:   op = rv_pkg::OR;
            rv_pkg::F3_AND:  op = rv_pkg::AND;
            default:         op = rv_pkg::ADD;
        endcase
        return op;
    endfunction

    // Same 32 bits seen through each layout
    assign ri = slot.instr.payload.ri;
    assign rr = slot.instr.payload.rr;
    assign u  = slot.instr.payload.u;

    always_comb begin
        cmd.valid   = slot.valid;
        cmd.illegal = 1'b0;
        cmd.rd      = rr.rd; // rd sits at the same bits in all layouts
        cmd.rs1     = '0;
        cmd.rs2     = '0;
        cmd.imm     = '0;
        cmd.useImm  = 1'b0;
        cmd.usePc   = 1'b0;
        cmd.aluOp   = rv_pkg::ADD;

        case (slot.instr.opCode)
            rv_pkg::OP: begin
                cmd.rs1   = rr.rs1;
                cmd.rs2   = rr.rs2;
                cmd.aluOp = mapFunct3(rr.funct3, rr.funct7[5], 1'b1);
            end
            rv_pkg::OP_IMM: begin
                cmd.rs1    = ri.rs1;
                cmd.imm    = rv_pkg::Word'($signed(ri.imm)); // Sign-extend imm[11:0]
                cmd.useImm = 1'b1;
                cmd.aluOp  = mapFunct3(ri.funct3, rr.funct7[5], 1'b0);
            end
            rv_pkg::LUI: begin
                cmd.imm    = {u.imm, 12'b0};
                cmd.useImm = 1'b1;
                cmd.aluOp  = rv_pkg::PASSB;
            end
            rv_pkg::AUIPC: begin
                cmd.imm    = {u.imm, 12'b0};
                cmd.useImm = 1'b1;
                cmd.usePc  = 1'b1;
                cmd.aluOp  = rv_pkg::ADD;
            end
            default: begin
                // Memory, control flow, system and unknown opcodes
                cmd.illegal = 1'b1;
            end
        endcase

        if (slot.malformed) begin
            cmd.illegal = 1'b1;
        end
    end

endmodule

// File: rv_issue.sv
`timescale 1ns/10ps

module rv_issue (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    input  rv_pkg::Instruction   instr,
    input  rv_pkg::Word          pc,
    output rv_pkg::IssueSlot     slot
);

    logic               validQ;
    rv_pkg::Instruction instrQ;
    rv_pkg::Word        pcQ;
    logic               malformedQ;

    // Valid follows the strobe, so an idle cycle empties the slot
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (instrValid) begin
            instrQ     <= instr;
            pcQ        <= pc;
            malformedQ <= (instr.lowBits != 2'b11); // Compressed or bad word
        end
    end

    always_comb begin
        slot.valid     = validQ;
        slot.instr     = instrQ;
        slot.pc        = pcQ;
        slot.malformed = malformedQ;
    end

endmodule

// File: rv_patterns.txt
# name instr(hex) pc(hex) kind(wb|illegal) rd(hex) data(hex)
# A line "--" ends a group; groups are issued back to back, gaps fall between groups
addi_neg      ffb00093 00000000 wb      01 fffffffb
addi_pos      06400113 00000004 wb      02 00000064
slti_neg      fff0a193 00000008 wb      03 00000001
sltiu_neg     fff13213 0000000c wb      04 00000001
sltiu_big     ff80b293 00000010 wb      05 00000000
xori_neg      fff14313 00000014 wb      06 ffffff9b
ori_neg       ff016393 00000018 wb      07 fffffff4
andi_neg      ff00f413 0000001c wb      08 fffffff0
slli          00409493 00000020 wb      09 ffffffb0
srli          0040d513 00000024 wb      0a 0fffffff
srai          4040d593 00000028 wb      0b ffffffff
--
add           00208633 0000002c wb      0c 0000005f
sub           402086b3 00000030 wb      0d ffffff97
sll           00311733 00000034 wb      0e 000000c8
slt_signed    0020a7b3 00000038 wb      0f 00000001
sltu_unsigned 0020b833 0000003c wb      10 00000000
xor           0020c8b3 00000040 wb      11 ffffff9f
srl           0030d933 00000044 wb      12 7ffffffd
sra           4030d9b3 00000048 wb      13 fffffffd
or            0020ea33 0000004c wb      14 ffffffff
and           0020fab3 00000050 wb      15 00000060
--
lui           abcdeb37 00000054 wb      16 abcde000
auipc_pos     00012b97 00001000 wb      17 00013000
auipc_neg     fffffc17 00002004 wb      18 00001004
--
chain_init    00700c93 00000100 wb      19 00000007
chain_addi    009c8c93 00000104 wb      19 00000010
chain_add     019c8d33 00000108 wb      1a 00000020
write_x0      005d0013 0000010c wb      00 00000000
read_x0       01a00db3 00000110 wb      1b 00000020
--
load          00012083 00000200 illegal 00 00000000
branch        00208463 00000204 illegal 00 00000000
system        00000073 00000208 illegal 00 00000000
low_bits_01   00100091 0000020c illegal 00 00000000
readback_x1   00008e13 00000210 wb      1c fffffffb
readback_x8   00040eb3 00000214 wb      1d fffffff0

// File: rv_pkg.sv
`include "rv_cfg.svh"

package rv_pkg;

    typedef logic [`RV_XLEN-1:0] Word;
    typedef logic [$clog2(`RV_NREGS)-1:0] RegAddr;

    // Major opcode, instr[6:2]
    typedef enum logic [4:0] {
        LOAD   = 5'b00000,
        STORE  = 5'b01000,
        OP_IMM = 5'b00100, // Register-immediate ALU
        OP     = 5'b01100, // Register-register ALU
        LUI    = 5'b01101,
        AUIPC  = 5'b00101,
        BRANCH = 5'b11000,
        JAL    = 5'b11011,
        JALR   = 5'b11001,
        SYSTEM = 5'b11100
    } OpCode;

    // funct3 encodings of the integer ALU group
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000, // ADD or SUB
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRLA = 3'b101, // SRL or SRA
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } Funct3;

    typedef struct packed {
        logic [11:0] imm;
        RegAddr rs1;
        Funct3 funct3;
        RegAddr rd;
    } RiInstr;

    typedef struct packed {
        logic [6:0] funct7; // Bit 5 picks SUB or SRA
        RegAddr rs2;
        RegAddr rs1;
        Funct3 funct3;
        RegAddr rd;
    } RrInstr;

    typedef struct packed {
        logic [19:0] imm;
        RegAddr rd;
    } UInstr;

    typedef union packed {
        RiInstr ri;
        RrInstr rr;
        UInstr u;
    } InstrPayload;

    typedef struct packed {
        InstrPayload payload;
        OpCode opCode;
        logic [1:0] lowBits; // Must be 11 for 32-bit encodings
    } Instruction;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
    } AluOp;

    typedef struct packed {
        logic valid;
        Instruction instr;
        Word pc;
        logic malformed;
    } IssueSlot;

    typedef struct packed {
        logic valid;
        logic illegal;
        RegAddr rd;
        RegAddr rs1;
        RegAddr rs2;
        Word imm;
        logic useImm; // B operand from imm
        logic usePc;  // A operand from pc
        AluOp aluOp;
    } ExecCmd;

    typedef struct packed {
        logic valid;
        RegAddr rd;
        Word data;
    } WbResult;

endpackage

// File: rv_regfile.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_regfile (
    input  logic           clk,
    input  logic           arstN,
    input  rv_pkg::RegAddr rs1,
    input  rv_pkg::RegAddr rs2,
    output rv_pkg::Word    rdata1,
    output rv_pkg::Word    rdata2,
    input  logic           writeEn,
    input  rv_pkg::RegAddr wAddr,
    input  rv_pkg::Word    wData
);

    localparam rv_pkg::RegAddr ZeroReg = rv_pkg::RegAddr'(`RV_X0);

    rv_pkg::Word regs [`RV_NREGS];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (wAddr != ZeroReg)) begin
            regs[wAddr] <= wData;
        end
    end

    // x0 reads zero whatever the array holds
    always_comb begin
        rdata1 = regs[rs1];
        rdata2 = regs[rs2];
        if (rs1 == ZeroReg) begin
            rdata1 = '0;
        end
        if (rs2 == ZeroReg) begin
            rdata2 = '0;
        end
    end

endmodule

// File: rv_retire.sv
`timescale 1ns/10ps
`include "rv_cfg.svh"

module rv_retire (
    input  logic           clk,
    input  logic           arstN,
    input  rv_pkg::ExecCmd cmd,
    input  rv_pkg::Word    aluResult,
    output rv_pkg::WbResult wb,
    output logic           illegal,
    output logic           writeEn,
    output rv_pkg::RegAddr wAddr,
    output rv_pkg::Word    wData
);

    localparam rv_pkg::RegAddr ZeroReg = rv_pkg::RegAddr'(`RV_X0);

    logic        retireOk;
    logic        wbValidQ;
    rv_pkg::RegAddr rdQ;
    rv_pkg::Word dataQ;

    assign retireOk = cmd.valid && !cmd.illegal;

    // Register file writes on the same edge as the writeback pulse
    assign writeEn = retireOk && (cmd.rd != ZeroReg);
    assign wAddr   = cmd.rd;
    assign wData   = aluResult;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbValidQ <= 1'b0;
            illegal  <= 1'b0;
        end else begin
            wbValidQ <= retireOk;
            illegal  <= cmd.valid && cmd.illegal;
        end
    end

    always_ff @(posedge clk) begin
        if (retireOk) begin
            rdQ   <= cmd.rd;
            dataQ <= (cmd.rd == ZeroReg) ? '0 : aluResult; // x0 reports 0
        end
    end

    assign wb = '{valid: wbValidQ, rd: rdQ, data: dataQ};

endmodule
